//--- decodeExec_golden.txt
# pc instr illegal wbEn wbRd wbData branchTaken target memValid memWrite memAddr memWdata
# All hex; columns that do not apply to an instruction hold zero
00000100 ffb00093 0 1 01 fffffffb 0 00000000 0 0 00000000 00000000
00000104 12345137 0 1 02 12345000 0 00000000 0 0 00000000 00000000
00000108 67810113 0 1 02 12345678 0 00000000 0 0 00000000 00000000
0000010c fff0a193 0 1 03 00000001 0 00000000 0 0 00000000 00000000
00000110 fff14213 0 1 04 edcba987 0 00000000 0 0 00000000 00000000
00000114 00409293 0 1 05 ffffffb0 0 00000000 0 0 00000000 00000000
00000118 4022d313 0 1 06 ffffffec 0 00000000 0 0 00000000 00000000
0000011c 00001397 0 1 07 0000111c 0 00000000 0 0 00000000 00000000
00000120 00138433 0 1 08 00001117 0 00000000 0 0 00000000 00000000
00000124 402404b3 0 1 09 edcbba9f 0 00000000 0 0 00000000 00000000
00000128 0084a533 0 1 0a 00000001 0 00000000 0 0 00000000 00000000
0000012c 0084b5b3 0 1 0b 00000000 0 00000000 0 0 00000000 00000000
00000130 0034d633 0 1 0c 76e5dd4f 0 00000000 0 0 00000000 00000000
00000134 4034d6b3 0 1 0d f6e5dd4f 0 00000000 0 0 00000000 00000000
00000138 00508013 0 0 00 00000000 0 00000000 0 0 00000000 00000000
0000013c 00200733 0 1 0e 12345678 0 00000000 0 0 00000000 00000000
00000140 00270463 0 0 00 00000000 1 00000148 0 0 00000000 00000000
00000144 fe2718e3 0 0 00 00000000 0 00000134 0 0 00000000 00000000
00000148 fe30c8e3 0 0 00 00000000 1 00000138 0 0 00000000 00000000
0000014c 0030d463 0 0 00 00000000 0 00000154 0 0 00000000 00000000
00000150 0030e463 0 0 00 00000000 0 00000158 0 0 00000000 00000000
00000154 fe30f8e3 0 0 00 00000000 1 00000144 0 0 00000000 00000000
00000158 fe3088e3 0 0 00 00000000 0 00000148 0 0 00000000 00000000
0000015c 00309463 0 0 00 00000000 1 00000164 0 0 00000000 00000000
00000160 0011c463 0 0 00 00000000 0 00000168 0 0 00000000 00000000
00000164 fe11d8e3 0 0 00 00000000 1 00000154 0 0 00000000 00000000
00000168 fe11e8e3 0 0 00 00000000 1 00000158 0 0 00000000 00000000
0000016c 0011f463 0 0 00 00000000 0 00000174 0 0 00000000 00000000
00000170 020007ef 0 1 0f 00000174 1 00000190 0 0 00000000 00000000
00000174 01110867 0 1 10 00000178 1 12345688 0 0 00000000 00000000
00000178 fe23ae23 0 0 00 00000000 0 00000000 1 1 00001118 12345678
0000017c 00842883 0 0 00 00000000 0 00000000 1 0 0000111f 00000000
00000180 0ff0018f 1 0 00 00000000 0 00000000 0 0 00000000 00000000
00000184 00018913 0 1 12 00000001 0 00000000 0 0 00000000 00000000

//--- tb.f
rvPkg.sv
instrDecoder.sv
regFile.sv
execUnit.sv
decodeExecTop.sv
decodeExec_checker.sv
tbDecodeExec.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing --assert
TOP       = tbDecodeExec
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = TESTBENCH PASSED

SOURCES = $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tbDecodeExec.sv
`timescale 1ns/1ps
`default_nettype none

module tbDecodeExec;
  import rvPkg::*;

  localparam int resultTimeout = 20;  // Cycles

  // One line of the golden file
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] illegal;
    logic [31:0] wbEn;
    logic [31:0] wbRd;
    logic [31:0] wbData;
    logic [31:0] branchTaken;
    logic [31:0] target;
    logic [31:0] memValid;
    logic [31:0] memWrite;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
  } goldenT;

  logic            clk;
  logic            rstN;
  logic            instrValid;
  logic [xlen-1:0] instr;
  logic [xlen-1:0] pc;
  execResultT      result;

  goldenT      golden;
  int          fd;
  int          nFields;
  int          itemCount;
  int          gap;
  string       line;

  decodeExecTop u_dut (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .pc         (pc),
    .result     (result)
  );

  always #2 clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected %08h, got %08h", $time, name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  // Strobe one instruction, then wait for its result and compare
  task automatic issueAndCheck(input goldenT exp);
    int waited;
    waited     = 0;
    instrValid = 1'b1;
    instr      = exp.instr;
    pc         = exp.pc;
    @(posedge clk);
    #1;
    instrValid = 1'b0;
    instr      = nopInstr;
    while (!result.valid) begin
      if (waited == resultTimeout) begin
        abortRun($sformatf("No result.valid within %0d cycles for pc %08h", waited, exp.pc));
      end
      @(posedge clk);
      #1;
      waited++;
    end
    checkValue("illegal", exp.illegal, 32'(result.illegal));
    checkValue("wb.en", exp.wbEn, 32'(result.wb.en));
    if (exp.wbEn[0]) begin
      checkValue("wb.rd", exp.wbRd, 32'(result.wb.rd));
      checkValue("wb.data", exp.wbData, result.wb.data);
    end
    checkValue("branchTaken", exp.branchTaken, 32'(result.branchTaken));
    if (exp.branchTaken[0] || (exp.instr[6:0] == 7'b1100011)) begin
      checkValue("target", exp.target, result.target);  // Not-taken branches too
    end
    checkValue("mem.valid", exp.memValid, 32'(result.mem.valid));
    if (exp.memValid[0]) begin
      checkValue("mem.write", exp.memWrite, 32'(result.mem.write));
      checkValue("mem.funct3", 32'(exp.instr[14:12]), 32'(result.mem.funct3));  // Access size
      checkValue("mem.addr", exp.memAddr, result.mem.addr);
      if (exp.memWrite[0]) begin
        checkValue("mem.wdata", exp.memWdata, result.mem.wdata);
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = nopInstr;
    pc         = '0;
    itemCount  = 0;
    void'($urandom(19054));
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;

    fd = $fopen("decodeExec_golden.txt", "r");
    if (fd == 0) begin
      abortRun("Cannot open decodeExec_golden.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line.getc(0) == 8'h23) begin
        continue;  // Empty or comment
      end
      nFields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        golden.pc, golden.instr, golden.illegal, golden.wbEn,
                        golden.wbRd, golden.wbData, golden.branchTaken, golden.target,
                        golden.memValid, golden.memWrite, golden.memAddr, golden.memWdata);
      if (nFields <= 0) begin
        continue;
      end
      if (nFields != 12) begin
        abortRun($sformatf("Golden entry %0d has %0d fields instead of 12",
                           itemCount + 1, nFields));
      end
      gap = $urandom_range(2, 0);  // Zero gives back-to-back strobes
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      issueAndCheck(golden);
      itemCount++;
    end
    $fclose(fd);

    if (itemCount == 0) begin
      abortRun("The golden file holds no instructions");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- decodeExec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decodeExec_checker (
  input logic              clk,
  input logic              rstN,
  input logic              instrValid,
  input rvPkg::execResultT result
);

  // One-cycle latency
  validFollowsStrobe: assert property (@(posedge clk) disable iff (!rstN)
    instrValid |=> result.valid)
    else $error("result.valid missing one cycle after instrValid");

  noSpuriousValid: assert property (@(posedge clk) disable iff (!rstN)
    !instrValid |=> !result.valid)
    else $error("result.valid without a preceding instrValid");

  // Synchronous reset clears the outputs at the next edge
  quietInReset: assert property (@(posedge clk)
    !rstN |=> !(result.valid || result.wb.en || result.mem.valid))
    else $error("Output strobe active during reset");

  illegalHasNoEffect: assert property (@(posedge clk) disable iff (!rstN)
    result.illegal |-> !(result.wb.en || result.mem.valid))
    else $error("Illegal instruction wrote a register or issued a memory request");

  // x0 is never a write target
  noWriteToX0: assert property (@(posedge clk) disable iff (!rstN)
    result.wb.en |-> (result.wb.rd != '0))
    else $error("Write-back enabled with rd of x0");

endmodule

bind decodeExecTop decodeExec_checker u_checker (
  .clk        (clk),
  .rstN       (rstN),
  .instrValid (instrValid),
  .result     (result)
);

`default_nettype wire

//--- decodeExecTop.sv
`timescale 1ns/1ps
`default_nettype none

module decodeExecTop (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  logic [rvPkg::xlen-1:0] instr,
  input  logic [rvPkg::xlen-1:0] pc,
  output rvPkg::execResultT      result
);
  import rvPkg::*;

  decodedT  decoded;
  operandsT operands;
  wbT       wb;

  instrDecoder u_instrDecoder (
    .instr   (instr),
    .decoded (decoded)
  );

  // Register reads run in parallel with decode
  regFile u_regFile (
    .clk      (clk),
    .rstN     (rstN),
    .rs1      (instr[19:15]),
    .rs2      (instr[24:20]),
    .operands (operands),
    .wb       (wb)
  );

  execUnit u_execUnit (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .pc         (pc),
    .decoded    (decoded),
    .operands   (operands),
    .wb         (wb),
    .result     (result)
  );

endmodule

`default_nettype wire

//--- execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  logic [rvPkg::xlen-1:0] pc,
  input  rvPkg::decodedT         decoded,
  input  rvPkg::operandsT        operands,
  output rvPkg::wbT              wb,
  output rvPkg::execResultT      result
);
  import rvPkg::*;

  logic [xlen-1:0] opA;
  logic [xlen-1:0] opB;
  logic [xlen-1:0] aluRes;
  logic [xlen-1:0] pcImm;
  logic [xlen-1:0] linkAddr;
  logic            useImm;
  logic            cmpTaken;
  logic            doWrite;
  execResultT      resultNext;

  assign useImm = decoded.op inside {opOpImm, opLoad, opStore, opJalr};

  assign opA      = operands.rs1Data;
  assign opB      = useImm ? decoded.imm : operands.rs2Data;
  assign pcImm    = pc + decoded.imm;
  assign linkAddr = pc + 32'd4;

  always_comb begin
    case (decoded.aluOp)
      aluAdd:  aluRes = opA + opB;
      aluSub:  aluRes = opA - opB;
      aluSll:  aluRes = opA << opB[4:0];
      aluSlt:  aluRes = {31'b0, $signed(opA) < $signed(opB)};
      aluSltu: aluRes = {31'b0, opA < opB};
      aluXor:  aluRes = opA ^ opB;
      aluSrl:  aluRes = opA >> opB[4:0];
      aluSra:  aluRes = $signed(opA) >>> opB[4:0];
      aluOr:   aluRes = opA | opB;
      aluAnd:  aluRes = opA & opB;
      default: aluRes = '0;
    endcase
  end

  // Decoder picked SUB, SLT or SLTU to match funct3
  always_comb begin
    case (decoded.funct3)
      3'b000:         cmpTaken = (aluRes == '0);
      3'b001:         cmpTaken = (aluRes != '0);
      3'b100, 3'b110: cmpTaken = aluRes[0];
      3'b101, 3'b111: cmpTaken = !aluRes[0];
      default:        cmpTaken = 1'b0;
    endcase
  end

  // Loads write nothing in this slice
  assign doWrite = (decoded.fmt inside {fmtU, fmtJ, fmtI, fmtR}) && (decoded.op != opLoad);

  always_comb begin
    wb.en = instrValid && !decoded.illegal && doWrite && (decoded.rd != '0);
    wb.rd = decoded.rd;
    case (decoded.op)
      opLui:         wb.data = decoded.imm;
      opAuipc:       wb.data = pcImm;
      opJal, opJalr: wb.data = linkAddr;
      default:       wb.data = aluRes;
    endcase
  end

  always_comb begin
    resultNext         = '0;
    resultNext.valid   = instrValid;
    resultNext.illegal = instrValid && decoded.illegal;
    resultNext.wb      = wb;

    if (instrValid && !decoded.illegal) begin
      case (decoded.op)
        opJal: begin
          resultNext.branchTaken = 1'b1;
          resultNext.target      = pcImm;
        end
        opJalr: begin
          resultNext.branchTaken = 1'b1;
          resultNext.target      = {aluRes[xlen-1:1], 1'b0};
        end
        opBranch: begin
          resultNext.branchTaken = cmpTaken;
          resultNext.target      = pcImm;  // Valid even when not taken
        end
        opLoad, opStore: begin
          resultNext.mem.valid  = 1'b1;
          resultNext.mem.write  = (decoded.op == opStore);
          resultNext.mem.funct3 = decoded.funct3;
          resultNext.mem.addr   = aluRes;
          if (decoded.op == opStore) begin
            resultNext.mem.wdata = operands.rs2Data;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Same edge as the register file write
  always_ff @(posedge clk) begin
    if (!rstN) begin
      result <= '0;
    end else begin
      result <= resultNext;
    end
  end

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic [rvPkg::regAddrW-1:0] rs1,
  input  logic [rvPkg::regAddrW-1:0] rs2,
  output rvPkg::operandsT            operands,
  input  rvPkg::wbT                  wb
);
  import rvPkg::*;

  // x0 has no storage
  logic [xlen-1:0] regs [1:regCount-1];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign operands.rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign operands.rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input  logic [rvPkg::xlen-1:0] instr,
  output rvPkg::decodedT         decoded
);
  import rvPkg::*;

  logic [xlen-1:0] immU;
  logic [xlen-1:0] immJ;
  logic [xlen-1:0] immB;
  logic [xlen-1:0] immI;
  logic [xlen-1:0] immS;
  logic [2:0]      funct3;
  logic            altBit;

  assign funct3 = instr[14:12];
  assign altBit = instr[30];  // funct7 bit 5

  assign immU = {instr[31:12], 12'h000};
  assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immI = {{21{instr[31]}}, instr[30:20]};
  assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};

  // OP and OPIMM share funct3 encodings, only OP has SUB
  function automatic aluOpE arithOp(input logic [2:0] f3, input logic alt,
                                    input logic regForm);
    case (f3)
      3'b000:  return (alt && regForm) ? aluSub : aluAdd;
      3'b001:  return aluSll;
      3'b010:  return aluSlt;
      3'b011:  return aluSltu;
      3'b100:  return aluXor;
      3'b101:  return alt ? aluSra : aluSrl;
      3'b110:  return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  // Compare kind for branches
  function automatic aluOpE cmpOp(input logic [2:0] f3);
    case (f3[2:1])
      2'b10:   return aluSlt;   // BLT, BGE
      2'b11:   return aluSltu;  // BLTU, BGEU
      default: return aluSub;   // BEQ, BNE
    endcase
  endfunction

  always_comb begin
    decoded    = '0;
    decoded.op = opcodeE'(instr[6:0]);

    case (instr[6:0])
      opLui, opAuipc: begin
        decoded.rd  = instr[11:7];
        decoded.imm = immU;
        decoded.fmt = fmtU;
      end

      opJal: begin
        decoded.rd  = instr[11:7];
        decoded.imm = immJ;
        decoded.fmt = fmtJ;
      end

      opBranch: begin
        decoded.rs1    = instr[19:15];
        decoded.rs2    = instr[24:20];
        decoded.funct3 = funct3;
        decoded.imm    = immB;
        decoded.fmt    = fmtB;
        decoded.aluOp  = cmpOp(funct3);
      end

      opJalr, opLoad, opOpImm: begin
        decoded.rd     = instr[11:7];
        decoded.rs1    = instr[19:15];
        decoded.funct3 = funct3;
        decoded.imm    = immI;
        decoded.fmt    = fmtI;
        if (instr[6:0] == opOpImm) begin
          decoded.aluOp = arithOp(funct3, altBit, 1'b0);
        end
      end

      opStore: begin
        decoded.rs1    = instr[19:15];
        decoded.rs2    = instr[24:20];
        decoded.funct3 = funct3;
        decoded.imm    = immS;
        decoded.fmt    = fmtS;
      end

      opOp: begin
        decoded.rd     = instr[11:7];
        decoded.rs1    = instr[19:15];
        decoded.rs2    = instr[24:20];
        decoded.funct3 = funct3;
        decoded.funct7 = instr[31:25];
        decoded.fmt    = fmtR;
        decoded.aluOp  = arithOp(funct3, altBit, 1'b1);
      end

      default: begin
        decoded.illegal = 1'b1;  // FENCE, SYSTEM and unknown
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rvPkg.sv
`default_nettype none

package rvPkg;

  localparam int xlen     = 32;
  localparam int regCount = 32;
  localparam int regAddrW = 5;
  localparam logic [xlen-1:0] nopInstr = 32'h0000_0013;  // ADDI x0, x0, 0

  // Major opcodes kept in this slice
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opOpImm  = 7'b0010011,
    opStore  = 7'b0100011,
    opOp     = 7'b0110011
  } opcodeE;

  typedef enum logic [2:0] {
    fmtNone = 3'd0,
    fmtU    = 3'd1,
    fmtJ    = 3'd2,
    fmtB    = 3'd3,
    fmtI    = 3'd4,
    fmtS    = 3'd5,
    fmtR    = 3'd6
  } instrFmtE;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd
  } aluOpE;

  typedef struct packed {
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    instrFmtE            fmt;
    opcodeE              op;
    aluOpE               aluOp;
    logic [xlen-1:0]     imm;
    logic                illegal;
  } decodedT;

  typedef struct packed {
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
  } operandsT;

  typedef struct packed {
    logic                en;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     data;
  } wbT;

  typedef struct packed {
    logic            valid;
    logic            write;
    logic [2:0]      funct3;  // Access size and sign
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
  } memReqT;

  typedef struct packed {
    logic            valid;
    logic            illegal;
    wbT              wb;
    logic            branchTaken;  // Also high for JAL and JALR
    logic [xlen-1:0] target;
    memReqT          mem;
  } execResultT;

endpackage

`default_nettype wire
